// File: cinh_stage.sv
// Stage two of the page-table pipeline, the cache-inhibit memory
// Addressed by PPN bits 13..0, bit 14 unused, data is PPN bit MAP_W-1
// A wclim_n write uses ppn_in, a lookup uses the PPN read in stage one
// A write and a valid lookup must not arrive in the same cycle
// The bit is stored inverted so a cleared memory and a reset read register
// both give wcinh_n high, which is inhibit inactive
module cinh_stage #(
  parameter int MAP_W = 16 // PPN word width
) (
  input  logic             sysclk,
  input  logic             rst_n,
  input  logic             wclim_n, // Inhibit memory write, active low
  input  logic [MAP_W-1:0] ppn_in,
  map_stage_if.dst         stage_in,
  output logic             wcinh_n  // Cache inhibit, active low
);

  localparam int AW = mmu_pt_pkg::CINH_AW; // Inhibit address width

  // PPN must hold the address, the unused bit and the data bit
  if (MAP_W < AW + 2) begin : g_width_check
    $error("cinh_stage: MAP_W must be at least CINH_AW + 2");
  end

  logic          lookup;   // Valid PPN lookup from stage one
  logic          cinh_we;  // Write request from wclim_n
  logic [AW-1:0] cinh_addr;
  logic          cinh_cs_n;
  logic          cinh_d;   // Inverted inhibit bit
  logic          cinh_q;   // Inverted inhibit read register

  assign lookup  = (stage_in.op == mmu_pt_pkg::OP_READ) && stage_in.ppn_hit;
  assign cinh_we = !wclim_n;

  // Write address wins, the pair is excluded by the assertion below
  assign cinh_addr = cinh_we ? ppn_in[AW-1:0] : stage_in.ppn[AW-1:0];
  assign cinh_cs_n = !(cinh_we || lookup); // Idle cycles hold the read register
  assign cinh_d    = !ppn_in[MAP_W-1];

  map_ram #(
    .ADDR_W(AW),
    .DATA_W(1)
  ) cinh_ram (
    .sysclk(sysclk),
    .rst_n (rst_n),
    .addr  (cinh_addr),
    .cs_n  (cinh_cs_n),
    .we_n  (wclim_n),
    .d     (cinh_d),
    .q     (cinh_q)
  );

  assign wcinh_n = !cinh_q; // Back to the stored polarity

  // Inhibit write and lookup result share the memory port
  a_no_collision: assert property (
    @(posedge sysclk) disable iff (!rst_n)
    !(cinh_we && lookup)
  ) else $error("cinh_stage: wclim_n write collides with a PPN lookup");

  // A lookup result arriving from stage one carries defined data
  a_lookup_known: assert property (
    @(posedge sysclk) disable iff (!rst_n)
    lookup |-> !$isunknown({stage_in.ppn, stage_in.pt})
  ) else $error("cinh_stage: unknown PT or PPN word on a valid lookup");

endmodule

// File: map_lookup_stage.sv
// Stage one of the page-table pipeline
// Holds the PT and PPN mapping memories, both addressed by logical address bits 20..10
// ept_n and epmap_n enable each memory, wmap_n is the shared write strobe
// Read data and the access kind are registered together and leave on stage_out
// Only the enabled memory updates its read register, the other one holds
module map_lookup_stage #(
  parameter int LA_W  = 11, // Logical address width
  parameter int MAP_W = 16  // PT and PPN word width
) (
  input  logic             sysclk,
  input  logic             rst_n,
  input  logic [LA_W-1:0]  la,      // Logical address bits 20..10
  input  logic             ept_n,   // PT memory enable, active low
  input  logic             epmap_n, // PPN memory enable, active low
  input  logic             wmap_n,  // Map write strobe, active low
  input  logic [MAP_W-1:0] pt_in,
  input  logic [MAP_W-1:0] ppn_in,
  output logic [MAP_W-1:0] pt_out,
  output logic [MAP_W-1:0] ppn_out,
  map_stage_if.src         stage_out
);

  mmu_pt_pkg::map_op_e op_d;    // Decoded access of this cycle
  mmu_pt_pkg::map_op_e op_q;    // Access kind aligned with read data
  logic                access;  // Either memory enabled
  logic                ppn_hit_q; // PPN memory was enabled
  logic [MAP_W-1:0]    pt_q;    // PT read register
  logic [MAP_W-1:0]    ppn_q;   // PPN read register

  assign access = !ept_n || !epmap_n;

  // Strobe decode
  always_comb begin
    if (!access) begin
      op_d = mmu_pt_pkg::OP_IDLE;
    end else if (!wmap_n) begin
      op_d = mmu_pt_pkg::OP_WRITE;
    end else begin
      op_d = mmu_pt_pkg::OP_READ;
    end
  end

  map_ram #(
    .ADDR_W(LA_W),
    .DATA_W(MAP_W)
  ) pt_ram (
    .sysclk(sysclk),
    .rst_n (rst_n),
    .addr  (la),
    .cs_n  (ept_n),
    .we_n  (wmap_n),
    .d     (pt_in),
    .q     (pt_q)
  );

  map_ram #(
    .ADDR_W(LA_W),
    .DATA_W(MAP_W)
  ) ppn_ram (
    .sysclk(sysclk),
    .rst_n (rst_n),
    .addr  (la),
    .cs_n  (epmap_n),
    .we_n  (wmap_n),
    .d     (ppn_in),
    .q     (ppn_q)
  );

  // Same edge as the memory read registers, so op lines up with the data
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      op_q      <= mmu_pt_pkg::OP_IDLE;
      ppn_hit_q <= 1'b0;
    end else begin
      op_q      <= op_d;
      ppn_hit_q <= !epmap_n;
    end
  end

  assign pt_out  = pt_q;
  assign ppn_out = ppn_q;

  assign stage_out.op      = op_q;
  assign stage_out.ppn_hit = ppn_hit_q;
  assign stage_out.ppn     = ppn_q;
  assign stage_out.pt      = pt_q;

  // A map write leaves both read registers as they were
  a_write_holds: assert property (
    @(posedge sysclk) disable iff (!rst_n)
    (op_q == mmu_pt_pkg::OP_WRITE) |-> ($stable(pt_q) && $stable(ppn_q))
  ) else $error("map_lookup_stage: read register changed on a map write");

endmodule

// File: map_ram.sv
// Synchronous single-port memory with a registered read port
// Write when cs_n and we_n are both low, read register loads when cs_n low, we_n high
// The read register holds its value in every other cycle
// Only the read register is cleared by rst_n. The array starts at zero after
// configuration and is never cleared by reset
module map_ram #(
  parameter int ADDR_W = 11, // Address width
  parameter int DATA_W = 16  // Word width
) (
  input  logic              sysclk,
  input  logic              rst_n,
  input  logic [ADDR_W-1:0] addr,
  input  logic              cs_n, // Chip enable, active low
  input  logic              we_n, // Write strobe, active low
  input  logic [DATA_W-1:0] d,
  output logic [DATA_W-1:0] q
);

  localparam int DEPTH = 2 ** ADDR_W; // Number of words

  logic [DATA_W-1:0] mem [DEPTH]; // Storage array
  logic              wr_en;       // Write this cycle
  logic              rd_en;       // Read register load this cycle

  assign wr_en = !cs_n && !we_n;
  assign rd_en = !cs_n && we_n;

  // Power-up contents, like a cleared SRAM after configuration
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge sysclk) begin
    if (wr_en) begin
      mem[addr] <= d; // Array write on the access edge
    end
  end

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else if (rd_en) begin
      q <= mem[addr]; // Data visible one cycle after the access
    end
  end

  // An enabled access must present a defined address
  a_addr_known: assert property (
    @(posedge sysclk) disable iff (!rst_n)
    !cs_n |-> !$isunknown({addr, we_n})
  ) else $error("map_ram: unknown address or strobe while cs_n low");

endmodule

// File: map_stage_if.sv
// Stage one to stage two link for one lookup result
// There is no handshake. op == OP_READ marks a valid result for one cycle
// All signals are registered in stage one and change only on sysclk
interface map_stage_if #(
  parameter int MAP_W = 16 // PT and PPN word width
);

  mmu_pt_pkg::map_op_e op;  // Access kind of the previous cycle
  logic               ppn_hit; // PPN memory was enabled in that access
  logic [MAP_W-1:0]   ppn;     // PPN memory read register
  logic [MAP_W-1:0]   pt;      // PT memory read register

  // Driven by the lookup stage
  modport src (
    output op,
    output ppn_hit,
    output ppn,
    output pt
  );

  // Read by the cache-inhibit stage
  modport dst (
    input op,
    input ppn_hit,
    input ppn,
    input pt
  );

endinterface

// File: mmu_pt_pkg.sv
// Shared types and constants for the MMU page-table slice
// map_op_e is two bits wide and is carried between the two pipeline stages
// CINH_AW sets the cache-inhibit memory depth as 2**CINH_AW one-bit entries
// The PPN word must be at least CINH_AW + 2 bits wide, and cinh_stage checks this
package mmu_pt_pkg;

  // Kind of access that stage one performed in a cycle
  typedef enum logic [1:0] {
    OP_IDLE  = 2'd0, // No chip enable low
    OP_READ  = 2'd1, // Enable low, wmap_n high
    OP_WRITE = 2'd2  // Enable low, wmap_n low
  } map_op_e;

  // Inhibit memory address width
  // PPN bits 13..0 address the memory, bit 14 is not decoded
  // and bit 15 is the data bit
  localparam int CINH_AW = 14;

endpackage

// File: mmu_pt_tb.sv
// Testbench for the MMU page-table slice
// Reference memories are associative arrays, unwritten map entries read as zero
// and unwritten inhibit entries read as inactive (high)
// One expected set of outputs is queued per driven cycle, tagged with its due cycle,
// and compared at the falling edge where DUT outputs are stable
// Stimulus never drops wclim_n in the cycle after a PPN read
module mmu_pt_tb;

  localparam int LA_W  = 11;
  localparam int MAP_W = 16;
  localparam int N_MAP = 32; // Random map entries
  localparam int N_INH = 6;  // Chosen inhibit entries
  localparam int SCHED = 16 + 2 * N_MAP + 3 * N_INH + 32; // Scheduled cycles
  localparam int LIMIT = 4 * SCHED;

  typedef struct packed {
    logic [MAP_W-1:0] pt;
    logic [MAP_W-1:0] ppn;
    logic             cinh_n;
  } outs_t;

  typedef struct packed {
    int               due; // Cycle in which the values must show
    logic [MAP_W-1:0] pt;
    logic [MAP_W-1:0] ppn;
    logic             cinh_n;
  } chk_t;

  logic             sysclk;
  logic             rst_n;
  logic [LA_W-1:0]  la;
  logic             ept_n;
  logic             epmap_n;
  logic             wmap_n;
  logic             wclim_n;
  logic [MAP_W-1:0] pt_in;
  logic [MAP_W-1:0] ppn_in;
  logic [MAP_W-1:0] pt_out;
  logic [MAP_W-1:0] ppn_out;
  logic             wcinh_n;

  logic [MAP_W-1:0] pt_mem [logic [LA_W-1:0]]; // Reference PT memory
  logic [MAP_W-1:0] ppn_mem [logic [LA_W-1:0]]; // Reference PPN memory
  logic             cinh_mem [logic [13:0]];    // Reference inhibit bits, stored polarity
  chk_t             exp_q [$];
  outs_t            model;     // pt/ppn one edge ahead, cinh_n two edges ahead
  logic [LA_W-1:0]  addr_list [N_MAP];
  int               cycle_cnt;
  int               seed;

  tb_clock_gen #(.PERIOD(40)) clk_gen (.sysclk(sysclk));

  mmu_pt_top #(
    .LA_W (LA_W),
    .MAP_W(MAP_W)
  ) UUT (
    .sysclk (sysclk),
    .rst_n  (rst_n),
    .la     (la),
    .ept_n  (ept_n),
    .epmap_n(epmap_n),
    .wmap_n (wmap_n),
    .wclim_n(wclim_n),
    .pt_in  (pt_in),
    .ppn_in (ppn_in),
    .pt_out (pt_out),
    .ppn_out(ppn_out),
    .wcinh_n(wcinh_n)
  );

  task automatic end_with_failure();
    $display("** FAIL **");
    $fatal(1);
  endtask

  // Next outputs after one cycle of strobes, memories already updated
  function automatic outs_t ref_outputs(input outs_t prev, input logic [LA_W-1:0] a,
                                        input logic ept, input logic epmap, input logic wmap);
    outs_t            nxt;
    logic [MAP_W-1:0] word;
    nxt = prev;
    if (wmap) begin // Write cycles leave all outputs alone
      if (!ept) begin
        nxt.pt = pt_mem.exists(a) ? pt_mem[a] : '0;
      end
      if (!epmap) begin
        word   = ppn_mem.exists(a) ? ppn_mem[a] : '0;
        nxt.ppn = word;
        nxt.cinh_n = cinh_mem.exists(word[13:0]) ? cinh_mem[word[13:0]] : 1'b1; // Bit 14 ignored
      end
    end
    return nxt;
  endfunction

  task automatic drive_cycle(input logic [LA_W-1:0] a, input logic ept, input logic epmap,
                             input logic wmap, input logic wclim,
                             input logic [MAP_W-1:0] pt_d, input logic [MAP_W-1:0] ppn_d);
    outs_t nxt;
    chk_t  c;
    @(posedge sysclk);
    la      <= a;
    ept_n   <= ept;
    epmap_n <= epmap;
    wmap_n  <= wmap;
    wclim_n <= wclim;
    pt_in   <= pt_d;
    ppn_in  <= ppn_d;
    if (!wclim) begin
      cinh_mem[ppn_d[13:0]] = ppn_d[MAP_W-1]; // Data bit is PPN bit 15
    end
    if (!wmap && !ept) begin
      pt_mem[a] = pt_d;
    end
    if (!wmap && !epmap) begin
      ppn_mem[a] = ppn_d;
    end
    nxt      = ref_outputs(model, a, ept, epmap, wmap);
    c.due    = cycle_cnt + 2; // Counter still shows the previous edge here
    c.pt     = nxt.pt;
    c.ppn    = nxt.ppn;
    c.cinh_n = model.cinh_n;  // Lookup from the cycle before lands now
    exp_q.push_back(c);
    model = nxt;
  endtask

  task automatic drive_idle(input int n);
    for (int i = 0; i < n; i++) begin
      drive_cycle('0, 1'b1, 1'b1, 1'b1, 1'b1, '0, '0);
    end
  endtask

  // Inhibit address for chosen entry i, spread over the 14-bit space
  function automatic logic [13:0] cinh_addr_of(input int i);
    return 14'(37 + 2911 * i);
  endfunction

  always @(posedge sysclk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  always @(posedge sysclk) begin
    if (cycle_cnt >= LIMIT) begin
      $display("timeout: test did not finish within %0d cycles", LIMIT);
      end_with_failure();
    end
  end

  always @(negedge sysclk) begin : compare
    chk_t c;
    while (exp_q.size() > 0 && exp_q[0].due <= cycle_cnt) begin
      c = exp_q.pop_front();
      assert (pt_out === c.pt) else begin
        $display("error: pt_out expected %h got %h (cycle %0d)", c.pt, pt_out, c.due);
        end_with_failure();
      end
      assert (ppn_out === c.ppn) else begin
        $display("error: ppn_out expected %h got %h (cycle %0d)", c.ppn, ppn_out, c.due);
        end_with_failure();
      end
      assert (wcinh_n === c.cinh_n) else begin
        $display("error: wcinh_n expected %h got %h (cycle %0d)", c.cinh_n, wcinh_n, c.due);
        end_with_failure();
      end
    end
  end

  initial begin : stimulus
    int r;
    int q;
    cycle_cnt = 0;
    seed      = 72;
    rst_n     = 1'b0;
    la        = '0;
    ept_n     = 1'b1;
    epmap_n   = 1'b1;
    wmap_n    = 1'b1;
    wclim_n   = 1'b1;
    pt_in     = '0;
    ppn_in    = '0;
    model     = '{pt: '0, ppn: '0, cinh_n: 1'b1}; // Reset state
    repeat (16) @(posedge sysclk);
    rst_n <= 1'b1;
    drive_idle(2); // Reset values

    // Random PT and PPN entries, then back-to-back reads
    for (int i = 0; i < N_MAP; i++) begin
      r = $random(seed);
      q = $random(seed);
      addr_list[i] = r[LA_W-1:0];
      drive_cycle(addr_list[i], 1'b0, 1'b0, 1'b0, 1'b1, r[31:16], q[15:0]);
    end
    for (int i = 0; i < N_MAP; i++) begin
      drive_cycle(addr_list[i], 1'b0, 1'b0, 1'b1, 1'b1, '0, '0);
    end

    // One enable at a time, the other output holds
    drive_cycle(addr_list[2], 1'b0, 1'b0, 1'b1, 1'b1, '0, '0);
    drive_cycle(addr_list[0], 1'b0, 1'b1, 1'b1, 1'b1, '0, '0);
    drive_cycle(addr_list[1], 1'b1, 1'b0, 1'b1, 1'b1, '0, '0);
    drive_idle(1); // Keeps wclim_n clear of the last PPN lookup

    // Inhibit bits, then PPN entries pointing at them, the last one unwritten
    for (int i = 0; i < N_INH; i++) begin
      drive_cycle('0, 1'b1, 1'b1, 1'b1, 1'b0, '0, {i[0], 1'b0, cinh_addr_of(i)});
    end
    for (int i = 0; i <= N_INH; i++) begin
      drive_cycle(LA_W'(1792 + i), 1'b1, 1'b0, 1'b0, 1'b1, '0, {1'b0, 1'b1, cinh_addr_of(i)});
    end
    for (int i = 0; i <= N_INH; i++) begin
      drive_cycle(LA_W'(1792 + i), 1'b1, 1'b0, 1'b1, 1'b1, '0, '0);
    end

    // Idle and write cycles hold all outputs
    drive_idle(3);
    drive_cycle(addr_list[5], 1'b0, 1'b0, 1'b0, 1'b1, 16'h5a5a, 16'h0001);
    drive_cycle('0, 1'b1, 1'b1, 1'b1, 1'b0, '0, {2'b00, cinh_addr_of(N_INH)});
    drive_idle(3);

    while (exp_q.size() > 0) begin
      @(posedge sysclk);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

// File: mmu_pt_top.sv
// Page-table slice of the MMU, two-stage pipeline on sysclk
// Reads give pt_out and ppn_out one cycle after the access edge
// A PPN read gives wcinh_n two cycles after the access edge
// Mapping memories are not cleared by reset, write before reading
// wclim_n must not be low in the cycle after a PPN read
module mmu_pt_top #(
  parameter int LA_W  = 11, // Logical address width, bits 20..10
  parameter int MAP_W = 16  // PT and PPN word width
) (
  input  logic             sysclk,
  input  logic             rst_n,
  input  logic [LA_W-1:0]  la,
  input  logic             ept_n,   // PT memory enable
  input  logic             epmap_n, // PPN memory enable
  input  logic             wmap_n,  // Map write strobe
  input  logic             wclim_n, // Inhibit memory write strobe
  input  logic [MAP_W-1:0] pt_in,
  input  logic [MAP_W-1:0] ppn_in,
  output logic [MAP_W-1:0] pt_out,
  output logic [MAP_W-1:0] ppn_out,
  output logic             wcinh_n
);

  map_stage_if #(
    .MAP_W(MAP_W)
  ) stage_bus ();

  map_lookup_stage #(
    .LA_W (LA_W),
    .MAP_W(MAP_W)
  ) u_lookup (
    .sysclk   (sysclk),
    .rst_n    (rst_n),
    .la       (la),
    .ept_n    (ept_n),
    .epmap_n  (epmap_n),
    .wmap_n   (wmap_n),
    .pt_in    (pt_in),
    .ppn_in   (ppn_in),
    .pt_out   (pt_out),
    .ppn_out  (ppn_out),
    .stage_out(stage_bus.src)
  );

  cinh_stage #(
    .MAP_W(MAP_W)
  ) u_cinh (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .wclim_n (wclim_n),
    .ppn_in  (ppn_in),
    .stage_in(stage_bus.dst),
    .wcinh_n (wcinh_n)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the MMU page-table slice testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module mmu_pt_tb -o mmu_pt_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/mmu_pt_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
  exit 0
fi
exit 1

// File: tb_clock_gen.sv
// Free-running testbench clock, low at time zero
// First rising edge after half a period, PERIOD should be even
module tb_clock_gen #(
  parameter int PERIOD = 40 // Clock period in time units
) (
  output logic sysclk
);

  initial begin
    sysclk = 1'b0;
    forever begin
      #(PERIOD / 2) sysclk = ~sysclk; // Half period per phase
    end
  end

endmodule

// File: vlog.f
mmu_pt_pkg.sv
map_stage_if.sv
map_ram.sv
map_lookup_stage.sv
cinh_stage.sv
mmu_pt_top.sv
tb_clock_gen.sv
mmu_pt_tb.sv
